// File: hw/i2c_ctrl_params.svh
`ifndef I2C_CTRL_PARAMS_SVH
`define I2C_CTRL_PARAMS_SVH

// host side memory words
`define MEM_W 32 // control and data word width

// wishbone side of the i2c master core
`define WB_ADR_W 3 // core register address
`define WB_DAT_W 8 // core register data, one byte

// fields carried in the control word
`define LEN_W 4 // byte count of a write
`define PRESCALE_W 16 // prescale split over two core registers

`endif

// File: hw/host_cmd_pkg.sv
`include "i2c_ctrl_params.svh"

package host_cmd_pkg;

	localparam int SLAVE_ADR_W = 7; // 7 bit i2c addressing only

	// host control word, lsb is the start flag
	typedef struct packed {
		logic [`PRESCALE_W-1:0] prescale; // 31:16
		logic                   spare; // 15, unused
		logic [`LEN_W-1:0]      byte_count; // 14:11
		logic [SLAVE_ADR_W-1:0] slave_addr; // 10:4
		logic                   set_prescale; // 3
		logic                   write; // 2
		logic                   read; // 1, no longer served
		logic                   start; // 0
	} host_ctrl_t;

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_WRITE,
		KIND_PRESCALE
	} cmd_kind_t;

	// write wins over prescale, a bare read decodes to nothing
	function automatic cmd_kind_t decode_cmd(host_ctrl_t c);
		cmd_kind_t kind;
		kind = KIND_NONE;
		if (c.start && c.write)
			kind = KIND_WRITE;
		else if (c.start && c.set_prescale)
			kind = KIND_PRESCALE;
		return kind;
	endfunction

endpackage

// File: hw/i2c_core_pkg.sv
`include "i2c_ctrl_params.svh"

package i2c_core_pkg;

	// register map of the i2c master core
	typedef enum logic [`WB_ADR_W-1:0] {
		REG_STATUS   = 3'd0, // read: busy, miss-ack
		REG_ADDR     = 3'd2, // slave address
		REG_CMD      = 3'd3, // command byte
		REG_FIFO     = 3'd4, // write fifo
		REG_PRESC_LO = 3'd6,
		REG_PRESC_HI = 3'd7
	} core_reg_t;

	// command register values
	typedef enum logic [`WB_DAT_W-1:0] {
		CMD_START       = 8'h04, // restart for a further byte
		CMD_START_WRITE = 8'h05, // start + write
		CMD_STOP        = 8'h10
	} core_cmd_t;

	// status register bits
	localparam int STATUS_BUSY_BIT     = 0;
	localparam int STATUS_MISS_ACK_BIT = 3; // only meaningful with busy low

endpackage

// File: hw/wb_access_if.sv
`include "i2c_ctrl_params.svh"

// one register access handed from the sequencer to the bus master
interface wb_access_if;

	logic                 req; // one cycle request
	logic [`WB_ADR_W-1:0] adr;
	logic [`WB_DAT_W-1:0] wdat;
	logic                 we; // 1 write, 0 read
	logic                 done; // one cycle, access finished
	logic [`WB_DAT_W-1:0] rdat; // valid with done

	modport requester (output req, adr, wdat, we, input done, rdat);

	modport performer (input req, adr, wdat, we, output done, rdat);

	// status watchers only look at the completions
	modport observer (input done, rdat);

endinterface

// File: hw/wb_access_unit.sv
`include "i2c_ctrl_params.svh"

module wb_access_unit (
	input  logic                 clk,
	input  logic                 nrst,
	wb_access_if.performer       acc,
	output logic [`WB_ADR_W-1:0] wbm_adr_o,
	output logic [`WB_DAT_W-1:0] wbm_dat_o,
	output logic                 wbm_we_o,
	output logic                 wbm_stb_o,
	output logic                 wbm_cyc_o,
	input  logic [`WB_DAT_W-1:0] wbm_dat_i,
	input  logic                 wbm_ack_i
);

	logic ack_seen; // access ends this cycle

	assign ack_seen = wbm_cyc_o && wbm_ack_i;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			wbm_adr_o <= '0;
			wbm_dat_o <= '0;
			wbm_we_o  <= 1'b0;
			wbm_stb_o <= 1'b0;
			wbm_cyc_o <= 1'b0;
			acc.done  <= 1'b0;
		end else begin
			wbm_stb_o <= 1'b0; // strobe only in the first cycle
			acc.done  <= 1'b0;
			if (acc.req) begin
				wbm_adr_o <= acc.adr; // held until ack
				wbm_dat_o <= acc.wdat;
				wbm_we_o  <= acc.we;
				wbm_stb_o <= 1'b1;
				wbm_cyc_o <= 1'b1;
			end else if (ack_seen) begin
				wbm_cyc_o <= 1'b0;
				wbm_we_o  <= 1'b0;
				acc.done  <= 1'b1;
			end
		end
	end

	// read data for the requester, valid alongside done
	always_ff @(posedge clk) begin
		if (ack_seen)
			acc.rdat <= wbm_dat_i;
	end

	// sequencer must wait for done before the next request
	a_no_req_while_open: assert property (@(posedge clk) disable iff (!nrst)
		wbm_cyc_o |-> !acc.req);

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!nrst)
		wbm_stb_o |-> wbm_cyc_o);

endmodule

// File: hw/tx_byte_loader.sv
`include "i2c_ctrl_params.svh"

module tx_byte_loader (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 load_i, // capture a new data word
	input  logic [`MEM_W-1:0]    data_i,
	input  logic [`LEN_W-1:0]    count_i, // bytes to hand out
	input  logic                 pop_i, // current byte taken
	output logic [`WB_DAT_W-1:0] byte_o,
	output logic                 last_o // nothing left to pop
);

	logic [`MEM_W-1:0] word_q;
	logic [`LEN_W-1:0] popped_q; // bytes handed out so far

	// lsb first, each pop moves the next byte down
	always_ff @(posedge clk) begin
		if (load_i)
			word_q <= data_i;
		else if (pop_i)
			word_q <= {{`WB_DAT_W{1'b0}}, word_q[`MEM_W-1:`WB_DAT_W]};
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			popped_q <= '0;
		end else if (load_i) begin
			popped_q <= '0; // new transfer
		end else if (pop_i) begin
			popped_q <= popped_q + 1'b1;
		end
	end

	assign byte_o = word_q[`WB_DAT_W-1:0];
	assign last_o = (popped_q == count_i); // sequencer needs no counter of its own

	// the sequencer stops popping once the count is reached
	a_no_pop_after_last: assert property (@(posedge clk) disable iff (!nrst)
		pop_i |-> !last_o);

endmodule

// File: hw/busy_monitor.sv
`include "i2c_ctrl_params.svh"

module busy_monitor
	import i2c_core_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	wb_access_if.observer     acc,
	input  logic              poll_i, // current access reads the status reg
	input  logic              arm_i, // new transfer starts
	input  logic [`LEN_W-1:0] count_i,
	output logic              busy_seen_o,
	output logic              byte_end_o,
	output logic              miss_ack_o,
	output logic              all_sent_o
);

	logic              busy_seen_q; // busy rose within this byte
	logic [`LEN_W-1:0] sent_q; // falling edges of busy so far
	logic              poll_done;
	logic              busy_now;

	assign poll_done = acc.done && poll_i;
	assign busy_now  = acc.rdat[STATUS_BUSY_BIT];

	// miss-ack is only trusted once the core is idle again
	assign miss_ack_o = poll_done && !busy_now && acc.rdat[STATUS_MISS_ACK_BIT];

	// busy back low after having been high
	assign byte_end_o = poll_done && busy_seen_q && !busy_now && !miss_ack_o;

	// counts the byte that is just finishing
	assign all_sent_o = byte_end_o && (sent_q + 1'b1 == count_i);

	assign busy_seen_o = busy_seen_q;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			busy_seen_q <= 1'b0;
			sent_q      <= '0;
		end else if (arm_i) begin
			busy_seen_q <= 1'b0;
			sent_q      <= '0;
		end else if (byte_end_o) begin
			busy_seen_q <= 1'b0; // wait for next rise
			sent_q      <= sent_q + 1'b1;
		end else if (poll_done && busy_now) begin
			busy_seen_q <= 1'b1;
		end
	end

endmodule

// File: hw/i2c_write_sequencer.sv
`include "i2c_ctrl_params.svh"

module i2c_write_sequencer
	import host_cmd_pkg::*;
	import i2c_core_pkg::*;
(
	input  logic                 clk,
	input  logic                 nrst,
	input  logic [`MEM_W-1:0]    memory_control_i,
	input  logic [`MEM_W-1:0]    memory_data_i,
	wb_access_if.requester       acc,
	output logic                 load_o, // loader
	output logic                 pop_o,
	output logic [`LEN_W-1:0]    count_o, // loader and monitor
	input  logic [`WB_DAT_W-1:0] byte_i,
	input  logic                 last_i,
	output logic                 poll_o, // monitor
	output logic                 arm_o,
	input  logic                 busy_seen_i,
	input  logic                 byte_end_i,
	input  logic                 miss_ack_i,
	input  logic                 all_sent_i,
	output logic                 busy_o,
	output logic                 done_o
);

	typedef enum logic [3:0] {
		S_IDLE, S_PRE_LO, S_PRE_HI, S_ADDR, S_FIFO,
		S_START, S_POLL, S_STOP, S_ABORT
	} state_t;

	state_t                state_q, state_d;
	host_ctrl_t            ctrl;
	cmd_kind_t             kind;
	logic                  issue; // launch an access next cycle
	logic [`WB_ADR_W-1:0]  adr_d;
	logic [`WB_DAT_W-1:0]  wdat_d;
	logic                  we_d;
	logic [`WB_DAT_W-1:0]  presc_hi_q; // second prescale write
	logic                  write_busy;

	assign ctrl = host_ctrl_t'(memory_control_i);
	assign kind = decode_cmd(ctrl); // sampled every idle cycle

	// the data word is captured by the loader at launch
	assign load_o = (state_q == S_IDLE) && (kind == KIND_WRITE);
	assign arm_o  = load_o;
	assign poll_o = (state_q == S_POLL);

	always_comb begin
		state_d = state_q;
		issue   = 1'b0;
		adr_d   = REG_STATUS;
		wdat_d  = '0;
		we_d    = 1'b0;
		pop_o   = 1'b0;
		case (state_q)
			S_IDLE: begin
				if (kind == KIND_WRITE) begin
					state_d = S_ADDR;
					issue   = 1'b1;
					adr_d   = REG_ADDR;
					wdat_d  = {1'b0, ctrl.slave_addr};
					we_d    = 1'b1;
				end else if (kind == KIND_PRESCALE) begin
					state_d = S_PRE_LO;
					issue   = 1'b1;
					adr_d   = REG_PRESC_LO;
					wdat_d  = ctrl.prescale[`WB_DAT_W-1:0];
					we_d    = 1'b1;
				end
			end
			S_PRE_LO: if (acc.done) begin
				state_d = S_PRE_HI;
				issue   = 1'b1;
				adr_d   = REG_PRESC_HI;
				wdat_d  = presc_hi_q;
				we_d    = 1'b1;
			end
			S_PRE_HI: if (acc.done)
				state_d = S_IDLE; // no done pulse for prescale
			S_ADDR, S_FIFO: if (acc.done) begin
				issue = 1'b1;
				we_d  = 1'b1;
				if (last_i) begin // fifo filled so the transfer can start
					state_d = S_START;
					adr_d   = REG_CMD;
					wdat_d  = CMD_START_WRITE;
				end else begin
					state_d = S_FIFO;
					adr_d   = REG_FIFO;
					wdat_d  = byte_i;
					pop_o   = 1'b1;
				end
			end
			S_START: if (acc.done) begin
				state_d = S_POLL;
				issue   = 1'b1; // first status read
			end
			S_POLL: if (acc.done) begin
				issue = 1'b1;
				if (miss_ack_i) begin
					state_d = S_ABORT;
					adr_d   = REG_CMD;
					wdat_d  = CMD_STOP;
					we_d    = 1'b1;
				end else if (byte_end_i) begin
					state_d = all_sent_i ? S_STOP : S_START;
					adr_d   = REG_CMD;
					wdat_d  = all_sent_i ? CMD_STOP : CMD_START;
					we_d    = 1'b1;
				end
				// otherwise poll status again
			end
			S_STOP, S_ABORT: if (acc.done)
				state_d = S_IDLE;
			default: state_d = S_IDLE;
		endcase
	end

	// busy covers every state of a write
	assign write_busy = state_d inside {S_ADDR, S_FIFO, S_START, S_POLL, S_STOP, S_ABORT};

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state_q <= S_IDLE;
			acc.req <= 1'b0;
			busy_o  <= 1'b0;
			done_o  <= 1'b0;
		end else begin
			state_q <= state_d;
			acc.req <= issue;
			busy_o  <= write_busy;
			done_o  <= (state_q == S_STOP) && acc.done; // aborts end silently
		end
	end

	// access payload and the fields latched from the idle control word
	always_ff @(posedge clk) begin
		if (issue) begin
			acc.adr  <= adr_d;
			acc.wdat <= wdat_d;
			acc.we   <= we_d;
		end
		if (state_q == S_IDLE) begin
			count_o    <= ctrl.byte_count;
			presc_hi_q <= ctrl.prescale[`PRESCALE_W-1:`WB_DAT_W];
		end
	end

	a_idle_not_both: assert property (@(posedge clk) disable iff (!nrst)
		(state_q == S_IDLE) |-> !(done_o && busy_o));

	// every byte starts with busy not yet seen
	a_byte_starts_unseen: assert property (@(posedge clk) disable iff (!nrst)
		(state_q == S_START) |-> !busy_seen_i);

endmodule

// File: hw/i2c_main_controller.sv
`include "i2c_ctrl_params.svh"

module i2c_main_controller (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic [`MEM_W-1:0]    memory_control_i, // host command word
	input  logic [`MEM_W-1:0]    memory_data_i, // bytes to send, lsb first
	output logic                 done_o,
	output logic                 busy_o,
	output logic [`WB_ADR_W-1:0] wbm_adr_o,
	output logic [`WB_DAT_W-1:0] wbm_dat_o,
	output logic                 wbm_we_o,
	output logic                 wbm_stb_o,
	output logic                 wbm_cyc_o,
	input  logic [`WB_DAT_W-1:0] wbm_dat_i,
	input  logic                 wbm_ack_i
);

	logic                 load, pop, last;
	logic [`LEN_W-1:0]    count;
	logic [`WB_DAT_W-1:0] tx_byte;
	logic                 poll, arm;
	logic                 busy_seen, byte_end, miss_ack, all_sent;

	wb_access_if acc ();

	wb_access_unit u_wb (
		.clk       (clk),
		.nrst      (nrst),
		.acc       (acc.performer),
		.wbm_adr_o (wbm_adr_o),
		.wbm_dat_o (wbm_dat_o),
		.wbm_we_o  (wbm_we_o),
		.wbm_stb_o (wbm_stb_o),
		.wbm_cyc_o (wbm_cyc_o),
		.wbm_dat_i (wbm_dat_i),
		.wbm_ack_i (wbm_ack_i)
	);

	tx_byte_loader u_loader (
		.clk     (clk),
		.nrst    (nrst),
		.load_i  (load),
		.data_i  (memory_data_i),
		.count_i (count),
		.pop_i   (pop),
		.byte_o  (tx_byte),
		.last_o  (last)
	);

	busy_monitor u_monitor (
		.clk         (clk),
		.nrst        (nrst),
		.acc         (acc.observer),
		.poll_i      (poll),
		.arm_i       (arm),
		.count_i     (count),
		.busy_seen_o (busy_seen),
		.byte_end_o  (byte_end),
		.miss_ack_o  (miss_ack),
		.all_sent_o  (all_sent)
	);

	i2c_write_sequencer u_seq (
		.clk              (clk),
		.nrst             (nrst),
		.memory_control_i (memory_control_i),
		.memory_data_i    (memory_data_i),
		.acc              (acc.requester),
		.load_o           (load),
		.pop_o            (pop),
		.count_o          (count),
		.byte_i           (tx_byte),
		.last_i           (last),
		.poll_o           (poll),
		.arm_o            (arm),
		.busy_seen_i      (busy_seen),
		.byte_end_i       (byte_end),
		.miss_ack_i       (miss_ack),
		.all_sent_i       (all_sent),
		.busy_o           (busy_o),
		.done_o           (done_o)
	);

endmodule

// File: testbench/i2c_core_model.sv
// behavioural i2c master core seen from its wishbone side
module i2c_core_model (
	input  logic       clk,
	input  logic       nrst,
	input  logic [2:0] adr_i,
	input  logic [7:0] dat_i,
	input  logic       we_i,
	input  logic       stb_i,
	input  logic       cyc_i,
	output logic [7:0] dat_o,
	output logic       ack_o,
	input  logic [1:0] ack_delay_i, // extra wait cycles before ack
	input  logic [1:0] busy_len_i, // extra busy polls per byte
	input  logic [3:0] miss_byte_i, // byte that gets no ack from the slave
	output logic       log_valid_o, // one cycle per register write
	output logic [2:0] log_adr_o,
	output logic [7:0] log_dat_o
);

	logic       pending_q; // access seen, ack not yet given
	logic [1:0] wait_q;
	int         busy_left; // polls still answering busy
	int         byte_idx; // byte of the current transfer

	// bus inputs of the controller are defined from time zero
	initial begin
		ack_o       = 1'b0;
		dat_o       = '0;
		log_valid_o = 1'b0;
		log_adr_o   = '0;
		log_dat_o   = '0;
	end

	always @(posedge clk) begin
		ack_o       <= 1'b0;
		log_valid_o <= 1'b0;
		if (!nrst) begin
			pending_q <= 1'b0;
			wait_q    <= '0;
			busy_left <= 0;
			byte_idx  <= 0;
			dat_o     <= '0;
		end else if (stb_i && cyc_i) begin
			pending_q <= 1'b1; // latch delay at the strobe
			wait_q    <= ack_delay_i;
		end else if (pending_q && wait_q != 0) begin
			wait_q <= wait_q - 1'b1;
		end else if (pending_q) begin
			pending_q <= 1'b0;
			ack_o     <= 1'b1;
			if (we_i) begin
				log_valid_o <= 1'b1;
				log_adr_o   <= adr_i;
				log_dat_o   <= dat_i;
				if (adr_i == 3'd3 && dat_i == 8'h05) begin
					byte_idx  <= 0; // first byte of a transfer
					busy_left <= busy_len_i + 1;
				end else if (adr_i == 3'd3 && dat_i == 8'h04) begin
					byte_idx  <= byte_idx + 1; // restart, next byte
					busy_left <= busy_len_i + 1;
				end
			end else if (adr_i == 3'd0) begin
				if (busy_left > 0) begin
					dat_o     <= 8'h01; // busy
					busy_left <= busy_left - 1;
				end else if (byte_idx == miss_byte_i) begin
					dat_o <= 8'h08; // idle with miss-ack
				end else begin
					dat_o <= 8'h00;
				end
			end
		end
	end

endmodule

// File: testbench/tb_i2c_main_controller.sv
module tb_i2c_main_controller;

	localparam int N_CMDS = 10;

	logic        clk = 1'b0;
	logic        nrst;
	logic [31:0] memory_control_i, memory_data_i;
	logic        done_o, busy_o;
	logic [2:0]  wbm_adr_o;
	logic [7:0]  wbm_dat_o, wbm_dat_i;
	logic        wbm_we_o, wbm_stb_o, wbm_cyc_o, wbm_ack_i;
	logic        log_valid;
	logic [2:0]  log_adr;
	logic [7:0]  log_dat;
	logic [1:0]  ack_delay, busy_len; // model knobs redrawn every cycle
	logic [15:0] lfsr_q;
	logic [31:0] knob_r;
	logic [31:0] cur_ctrl, cur_data; // command under test
	logic [3:0]  cur_miss; // 15 means every byte is acked
	int          log_idx, done_cnt;
	logic [31:0] rnd_data [N_CMDS];
	logic [31:0] rnd_ctrl [N_CMDS];

	i2c_main_controller i2c_main_controller_i (
		.clk(clk), .nrst(nrst),
		.memory_control_i(memory_control_i), .memory_data_i(memory_data_i),
		.done_o(done_o), .busy_o(busy_o),
		.wbm_adr_o(wbm_adr_o), .wbm_dat_o(wbm_dat_o), .wbm_we_o(wbm_we_o),
		.wbm_stb_o(wbm_stb_o), .wbm_cyc_o(wbm_cyc_o),
		.wbm_dat_i(wbm_dat_i), .wbm_ack_i(wbm_ack_i)
	);

	i2c_core_model core_model_i (
		.clk(clk), .nrst(nrst),
		.adr_i(wbm_adr_o), .dat_i(wbm_dat_o), .we_i(wbm_we_o),
		.stb_i(wbm_stb_o), .cyc_i(wbm_cyc_o),
		.dat_o(wbm_dat_i), .ack_o(wbm_ack_i),
		.ack_delay_i(ack_delay), .busy_len_i(busy_len), .miss_byte_i(cur_miss),
		.log_valid_o(log_valid), .log_adr_o(log_adr), .log_dat_o(log_dat)
	);

	always #4 clk = ~clk;

	// x16 + x14 + x13 + x11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]}; // one step per bit
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// 1 write, 2 prescale, 0 ignored
	function automatic int cmd_kind(input logic [31:0] ctrl);
		if (ctrl[0] && ctrl[2])
			return 1;
		if (ctrl[0] && ctrl[3])
			return 2;
		return 0;
	endfunction

	// expected i-th register write as {valid, adr, dat}
	function automatic logic [11:0] ref_entry(input logic [31:0] ctrl,
		input logic [31:0] data, input logic [3:0] miss, input int i);
		int          n;
		int          r;
		logic [11:0] e;
		n = ctrl[14:11];
		r = (miss < n) ? miss : n - 1; // restarts before the stop
		e = '0;
		if (cmd_kind(ctrl) == 1) begin
			if (i == 0)
				e = {1'b1, 3'd2, 1'b0, ctrl[10:4]}; // slave address
			else if (i <= n)
				e = {1'b1, 3'd4, data[8*(i-1) +: 8]}; // fifo bytes lsb first
			else if (i == n + 1)
				e = {1'b1, 3'd3, 8'h05};
			else if (i <= n + 1 + r)
				e = {1'b1, 3'd3, 8'h04};
			else if (i == n + 2 + r)
				e = {1'b1, 3'd3, 8'h10};
		end else if (cmd_kind(ctrl) == 2) begin
			if (i == 0)
				e = {1'b1, 3'd6, ctrl[23:16]};
			else if (i == 1)
				e = {1'b1, 3'd7, ctrl[31:24]};
		end
		return e;
	endfunction

	// entries up to the first invalid one
	function automatic int ref_len(input logic [31:0] ctrl, input logic [3:0] miss);
		int          n;
		logic [11:0] e;
		n = 0;
		e = ref_entry(ctrl, 32'h0, miss, 0);
		while (e[11]) begin
			n++;
			e = ref_entry(ctrl, 32'h0, miss, n);
		end
		return n;
	endfunction

	function automatic logic [31:0] write_word(input logic [31:0] rnd, input logic [3:0] n);
		return {rnd[31:16], 1'b0, n, rnd[6:0], 4'b0101}; // start + write
	endfunction

	always @(negedge clk) begin
		take_bits(2, knob_r);
		ack_delay = knob_r[1:0];
		take_bits(2, knob_r);
		busy_len = knob_r[1:0];
	end

	// logged writes against the reference plus busy and bus rules
	always @(posedge clk) begin
		if (log_valid) begin
			check_value("write expected", 1'b1, ref_entry(cur_ctrl, cur_data, cur_miss,
				log_idx) >> 11);
			check_value("write entry", {log_adr, log_dat},
				ref_entry(cur_ctrl, cur_data, cur_miss, log_idx) & 12'h7ff);
			log_idx++;
		end
		if (nrst && cmd_kind(cur_ctrl) == 2)
			check_value("busy during prescale", busy_o, 1'b0);
		if (nrst && cmd_kind(cur_ctrl) == 1 && wbm_stb_o)
			check_value("busy during write", busy_o, 1'b1);
		if (nrst && cmd_kind(cur_ctrl) == 0)
			check_value("strobe on ignored command", wbm_stb_o, 1'b0);
		if (done_o)
			done_cnt++;
	end

	task automatic apply_reset();
		nrst = 1'b0;
		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			check_value("cyc in reset", wbm_cyc_o, 1'b0);
			check_value("stb in reset", wbm_stb_o, 1'b0);
			check_value("busy in reset", busy_o, 1'b0);
			check_value("done in reset", done_o, 1'b0);
		end
		nrst = 1'b1;
	endtask

	task automatic launch(input logic [31:0] ctrl, input logic [31:0] data,
		input logic [3:0] miss);
		@(negedge clk);
		cur_ctrl         = ctrl;
		cur_data         = data;
		cur_miss         = miss;
		log_idx          = 0;
		done_cnt         = 0;
		memory_data_i    = data;
		memory_control_i = ctrl;
		@(negedge clk);
		memory_control_i = ctrl & 32'hffff_fffe; // start for one cycle
	endtask

	task automatic run_cmd(input logic [31:0] ctrl, input logic [31:0] data,
		input logic [3:0] miss);
		int len;
		int exp_done;
		len      = ref_len(ctrl, miss);
		exp_done = (cmd_kind(ctrl) == 1 && miss >= ctrl[14:11]) ? 1 : 0;
		launch(ctrl, data, miss);
		while (log_idx < len)
			@(negedge clk);
		while (wbm_cyc_o || busy_o)
			@(negedge clk);
		repeat (20) @(negedge clk); // idle settle to catch late extras
		check_value("done pulses", done_cnt, exp_done);
	endtask

	initial begin
		repeat (N_CMDS * 2000) @(posedge clk);
		$display("timeout: controller never finished");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		nrst             = 1'b0;
		memory_control_i = '0;
		memory_data_i    = '0;
		ack_delay        = '0;
		busy_len         = '0;
		cur_ctrl         = '0;
		cur_data         = '0;
		cur_miss         = 4'hf;
		log_idx          = 0;
		done_cnt         = 0;
		lfsr_q           = 16'd91;
		for (int k = 0; k < N_CMDS; k++) begin
			take_bits(32, rnd_data[k]);
			take_bits(32, rnd_ctrl[k]);
		end
		apply_reset();
		run_cmd({rnd_ctrl[0][15:0], 16'h0009}, rnd_data[0], 4'hf); // prescale
		for (int n = 1; n <= 4; n++)
			run_cmd(write_word(rnd_ctrl[n], n), rnd_data[n], 4'hf);
		run_cmd(write_word(rnd_ctrl[5], 3), rnd_data[5], 4'd1); // abort on byte 1
		run_cmd(write_word(rnd_ctrl[6], 2), rnd_data[6], 4'hf);
		launch(write_word(rnd_ctrl[7], 4), rnd_data[7], 4'hf);
		while (log_idx < 3)
			@(negedge clk);
		apply_reset(); // mid write
		run_cmd(write_word(rnd_ctrl[8], 2), rnd_data[8], 4'hf);
		run_cmd(32'h0000_0003, rnd_data[9], 4'hf); // bare read
		$display("All checks passed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hw
hw/host_cmd_pkg.sv
hw/i2c_core_pkg.sv
hw/wb_access_if.sv
hw/wb_access_unit.sv
hw/tx_byte_loader.sv
hw/busy_monitor.sv
hw/i2c_write_sequencer.sv
hw/i2c_main_controller.sv
testbench/i2c_core_model.sv
testbench/tb_i2c_main_controller.sv
